// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
TOP       := jtag_top_tb
FILELIST  := jtag_top.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# A $fatal in the run gives a nonzero exit status
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/jtag_top.sv
// Top level with master TAP, network and two slave TAPs
`timescale 1ns/1ps
`include "tap_consts.svh"

module jtag_top (
    input  logic                   tck,
    input  logic                   arst_n,
    input  logic                   tms,
    input  logic                   tdi,
    output logic                   tdo,
    output logic                   tdo_en,
    output tapnw_pkg::tap_enable_t tap_enable
);

    logic master_tdo;
    logic master_tdo_en;
    logic slave_tdo_en_any;

    tap_if stap0_if ();
    tap_if stap1_if ();

    master_tap mtap_i (.tck(tck), .arst_n(arst_n), .tms(tms), .tdi(tdi),
        .master_tdo(master_tdo), .tdo_en(master_tdo_en), .tap_enable(tap_enable));

    tap_network tapnw_i (.tms(tms), .master_tdo(master_tdo), .tap_enable(tap_enable),
        .tdo(tdo), .slave_tdo_en_any(slave_tdo_en_any), .stap0(stap0_if.net),
        .stap1(stap1_if.net));

    // Slaves differ only in IDCODE
    slave_tap #(.idcode(`STAP0_IDCODE)) stap0_i (.tck(tck), .arst_n(arst_n), .jtag(stap0_if.tap));
    slave_tap #(.idcode(`STAP1_IDCODE)) stap1_i (.tck(tck), .arst_n(arst_n), .jtag(stap1_if.tap));

    assign tdo_en = master_tdo_en | slave_tdo_en_any;

endmodule

// File: design/master_tap.sv
// Master TAP with IR, IDCODE, BYPASS and network select register
`timescale 1ns/1ps
`include "tap_consts.svh"

module master_tap (
    input  logic                   tck,
    input  logic                   arst_n,
    input  logic                   tms,
    input  logic                   tdi,
    output logic                   master_tdo,
    output logic                   tdo_en,
    output tapnw_pkg::tap_enable_t tap_enable
);

    tap_pkg::tap_state_e    state;
    tap_pkg::tap_instr_e    ir;
    logic [`TAP_IR_W-1:0]   ir_shift;
    logic [`TAP_ID_W-1:0]   id_shift;
    tapnw_pkg::tap_enable_t nw_shift;
    logic                   byp;
    logic                   upd_ir;
    logic                   upd_dr;
    logic                   sel_id;
    logic                   sel_nw;

    tap_fsm fsm_i (
        .tck    (tck),
        .arst_n (arst_n),
        .tms    (tms),
        .state  (state)
    );

    // Edges into the Update states
    assign upd_ir = tms && (state == tap_pkg::TAP_EXIT1_IR || state == tap_pkg::TAP_EXIT2_IR);
    assign upd_dr = tms && (state == tap_pkg::TAP_EXIT1_DR || state == tap_pkg::TAP_EXIT2_DR);
    // Unknown codes select BYPASS
    assign sel_id = (ir == tap_pkg::INSTR_IDCODE);
    assign sel_nw = (ir == tap_pkg::INSTR_NWSEL);

    // --------------------------------------------------
    // Instruction register
    // --------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == tap_pkg::TAP_CAP_IR) begin
            ir_shift <= `TAP_IR_CAPTURE;
        end else if (state == tap_pkg::TAP_SHIFT_IR) begin
            ir_shift <= {tdi, ir_shift[`TAP_IR_W-1:1]};
        end
    end

    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            ir <= tap_pkg::INSTR_IDCODE;
        end else if (state == tap_pkg::TAP_TLR) begin
            ir <= tap_pkg::INSTR_IDCODE;
        end else if (upd_ir) begin
            ir <= tap_pkg::tap_instr_e'(ir_shift);
        end
    end

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------
    // Select stage captures the live mask
    always_ff @(posedge tck) begin
        if (state == tap_pkg::TAP_CAP_DR) begin
            id_shift <= `MTAP_IDCODE;
            nw_shift <= tap_enable;
            byp      <= 1'b0;
        end else if (state == tap_pkg::TAP_SHIFT_DR) begin
            id_shift <= {tdi, id_shift[`TAP_ID_W-1:1]};
            nw_shift <= {tdi, nw_shift[`TAPNW_NUM_STAPS-1:1]};
            byp      <= tdi;
        end
    end

    // Slave enables survive Test-Logic-Reset
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            tap_enable <= '0;
        end else if (upd_dr && sel_nw) begin
            tap_enable <= nw_shift;
        end
    end

    assign master_tdo = (state == tap_pkg::TAP_SHIFT_IR) ? ir_shift[0] :
                        sel_id ? id_shift[0] :
                        sel_nw ? nw_shift[0] : byp;
    assign tdo_en     = (state == tap_pkg::TAP_SHIFT_IR) || (state == tap_pkg::TAP_SHIFT_DR);

    // Mask moves only on entry to Update-DR under NWSEL
    a_enable_update: assert property (@(posedge tck) disable iff (!arst_n)
        $changed(tap_enable) |->
            (state == tap_pkg::TAP_UPD_DR) && (ir == tap_pkg::INSTR_NWSEL));

endmodule

// File: design/slave_tap.sv
// Slave TAP with IR, IDCODE and BYPASS registers
`timescale 1ns/1ps
`include "tap_consts.svh"

module slave_tap #(
    parameter logic [`TAP_ID_W-1:0] idcode = `STAP0_IDCODE
) (
    input logic tck,
    input logic arst_n,
    tap_if.tap  jtag
);

    tap_pkg::tap_state_e  state;
    tap_pkg::tap_instr_e  ir;
    logic [`TAP_IR_W-1:0] ir_shift;
    logic [`TAP_ID_W-1:0] id_shift;
    logic                 byp;
    logic                 upd_ir;
    logic                 sel_id;

    tap_fsm fsm_i (
        .tck    (tck),
        .arst_n (arst_n),
        .tms    (jtag.tms),
        .state  (state)
    );

    // Edge into Update-IR
    assign upd_ir = jtag.tms &&
                    (state == tap_pkg::TAP_EXIT1_IR || state == tap_pkg::TAP_EXIT2_IR);
    // Anything but IDCODE falls back to BYPASS
    assign sel_id = (ir == tap_pkg::INSTR_IDCODE);

    // --------------------------------------------------
    // Instruction register
    // --------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == tap_pkg::TAP_CAP_IR) begin
            ir_shift <= `TAP_IR_CAPTURE;
        end else if (state == tap_pkg::TAP_SHIFT_IR) begin
            ir_shift <= {jtag.tdi, ir_shift[`TAP_IR_W-1:1]};
        end
    end

    // Hold register, back to IDCODE in Test-Logic-Reset
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            ir <= tap_pkg::INSTR_IDCODE;
        end else if (state == tap_pkg::TAP_TLR) begin
            ir <= tap_pkg::INSTR_IDCODE;
        end else if (upd_ir) begin
            ir <= tap_pkg::tap_instr_e'(ir_shift);
        end
    end

    // --------------------------------------------------
    // Data registers
    // --------------------------------------------------
    always_ff @(posedge tck) begin
        if (state == tap_pkg::TAP_CAP_DR) begin
            id_shift <= idcode;
            byp      <= 1'b0;
        end else if (state == tap_pkg::TAP_SHIFT_DR) begin
            id_shift <= {jtag.tdi, id_shift[`TAP_ID_W-1:1]};
            byp      <= jtag.tdi;
        end
    end

    // Serial out from the low bit of the selected register
    assign jtag.tdo    = (state == tap_pkg::TAP_SHIFT_IR) ? ir_shift[0] :
                         sel_id ? id_shift[0] : byp;
    assign jtag.tdo_en = (state == tap_pkg::TAP_SHIFT_IR) || (state == tap_pkg::TAP_SHIFT_DR);

endmodule

// File: design/tap_consts.svh
// Register widths, slave count, IDCODE values and opcodes
`ifndef TAP_CONSTS_SVH
`define TAP_CONSTS_SVH

`define TAP_IR_W        4
`define TAP_ID_W        32
`define TAPNW_NUM_STAPS 2
`define TAP_IR_CAPTURE  4'b0001

// Opcodes
`define TAP_OP_IDCODE   4'h2
`define TAP_OP_NWSEL    4'h8
`define TAP_OP_BYPASS   4'hF

// IDCODE values, bit 0 set as 1149.1 requires
`define MTAP_IDCODE     32'h1234_5679
`define STAP0_IDCODE    32'h1111_1113
`define STAP1_IDCODE    32'h2222_2223
`endif

// File: design/tap_fsm.sv
// 16-state TAP controller with assertions
`timescale 1ns/1ps

module tap_fsm (
    input  logic                tck,
    input  logic                arst_n,
    input  logic                tms,
    output tap_pkg::tap_state_e state
);

    tap_pkg::tap_state_e next_state;

    // --------------------------------------------------
    // Next-state table
    // --------------------------------------------------
    always_comb begin
        case (state)
            tap_pkg::TAP_TLR:      next_state = tms ? tap_pkg::TAP_TLR      : tap_pkg::TAP_RTI;
            tap_pkg::TAP_RTI:      next_state = tms ? tap_pkg::TAP_SEL_DR   : tap_pkg::TAP_RTI;
            tap_pkg::TAP_SEL_DR:   next_state = tms ? tap_pkg::TAP_SEL_IR   : tap_pkg::TAP_CAP_DR;
            tap_pkg::TAP_CAP_DR:   next_state = tms ? tap_pkg::TAP_EXIT1_DR : tap_pkg::TAP_SHIFT_DR;
            tap_pkg::TAP_SHIFT_DR: next_state = tms ? tap_pkg::TAP_EXIT1_DR : tap_pkg::TAP_SHIFT_DR;
            tap_pkg::TAP_EXIT1_DR: next_state = tms ? tap_pkg::TAP_UPD_DR   : tap_pkg::TAP_PAUSE_DR;
            tap_pkg::TAP_PAUSE_DR: next_state = tms ? tap_pkg::TAP_EXIT2_DR : tap_pkg::TAP_PAUSE_DR;
            tap_pkg::TAP_EXIT2_DR: next_state = tms ? tap_pkg::TAP_UPD_DR   : tap_pkg::TAP_SHIFT_DR;
            tap_pkg::TAP_UPD_DR:   next_state = tms ? tap_pkg::TAP_SEL_DR   : tap_pkg::TAP_RTI;
            // IR column mirrors DR, except Select-IR escapes to reset
            tap_pkg::TAP_SEL_IR:   next_state = tms ? tap_pkg::TAP_TLR      : tap_pkg::TAP_CAP_IR;
            tap_pkg::TAP_CAP_IR:   next_state = tms ? tap_pkg::TAP_EXIT1_IR : tap_pkg::TAP_SHIFT_IR;
            tap_pkg::TAP_SHIFT_IR: next_state = tms ? tap_pkg::TAP_EXIT1_IR : tap_pkg::TAP_SHIFT_IR;
            tap_pkg::TAP_EXIT1_IR: next_state = tms ? tap_pkg::TAP_UPD_IR   : tap_pkg::TAP_PAUSE_IR;
            tap_pkg::TAP_PAUSE_IR: next_state = tms ? tap_pkg::TAP_EXIT2_IR : tap_pkg::TAP_PAUSE_IR;
            tap_pkg::TAP_EXIT2_IR: next_state = tms ? tap_pkg::TAP_UPD_IR   : tap_pkg::TAP_SHIFT_IR;
            tap_pkg::TAP_UPD_IR:   next_state = tms ? tap_pkg::TAP_SEL_DR   : tap_pkg::TAP_RTI;
            default:               next_state = tap_pkg::TAP_TLR;
        endcase
    end

    // State register
    always_ff @(posedge tck or negedge arst_n) begin
        if (!arst_n) begin
            state <= tap_pkg::TAP_TLR;
        end else begin
            state <= next_state;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------
    // Five tms-high edges from any state end in Test-Logic-Reset
    a_tms_reset: assert property (@(posedge tck) disable iff (!arst_n)
        tms [*5] |=> state == tap_pkg::TAP_TLR);

    a_state_known: assert property (@(posedge tck) disable iff (!arst_n)
        !$isunknown(state));

endmodule

// File: design/tap_if.sv
// JTAG connection between the network and one slave TAP
`timescale 1ns/1ps

interface tap_if;

    // Gated by the network
    logic tms;
    // Serial data from the previous chain stage
    logic tdi;
    // Serial data back from the slave
    logic tdo;
    // Slave is in a Shift state
    logic tdo_en;

    modport net (output tms, output tdi, input tdo, input tdo_en);

    modport tap (input tms, input tdi, output tdo, output tdo_en);

endinterface

// File: design/tap_network.sv
// Routes tms and serial data through the enabled slave TAPs
`timescale 1ns/1ps

module tap_network (
    input  logic                   tms,
    input  logic                   master_tdo,
    input  tapnw_pkg::tap_enable_t tap_enable,
    output logic                   tdo,
    output logic                   slave_tdo_en_any,
    tap_if.net                     stap0,
    tap_if.net                     stap1
);

    tapnw_pkg::tap_pos_e last_pos;
    logic                stap0_out;

    // Disabled slaves see tms high and park in Test-Logic-Reset
    assign stap0.tms = tms | ~tap_enable[0];
    assign stap1.tms = tms | ~tap_enable[1];

    // Chain in index order, disabled stage bypassed by wire
    assign stap0.tdi = master_tdo;
    assign stap0_out = tap_enable[0] ? stap0.tdo : master_tdo;
    assign stap1.tdi = stap0_out;

    // Last enabled stage drives the port
    assign last_pos = tap_enable[1] ? tapnw_pkg::POS_STAP1 :
                      tap_enable[0] ? tapnw_pkg::POS_STAP0 : tapnw_pkg::POS_MTAP;

    always_comb begin
        case (last_pos)
            tapnw_pkg::POS_STAP1: tdo = stap1.tdo;
            tapnw_pkg::POS_STAP0: tdo = stap0.tdo;
            default:              tdo = master_tdo;
        endcase
    end

    assign slave_tdo_en_any = (tap_enable[0] & stap0.tdo_en) | (tap_enable[1] & stap1.tdo_en);

endmodule

// File: design/tap_pkg.sv
// TAP controller state encoding and instruction opcodes
`include "tap_consts.svh"

package tap_pkg;

    // IEEE 1149.1 controller states, standard 4-bit encoding
    typedef enum logic [3:0] {
        TAP_EXIT2_DR = 4'h0, TAP_EXIT1_DR = 4'h1, TAP_SHIFT_DR = 4'h2, TAP_PAUSE_DR  = 4'h3,
        TAP_SEL_IR   = 4'h4, TAP_UPD_DR   = 4'h5, TAP_CAP_DR   = 4'h6, TAP_SEL_DR    = 4'h7,
        TAP_EXIT2_IR = 4'h8, TAP_EXIT1_IR = 4'h9, TAP_SHIFT_IR = 4'hA, TAP_PAUSE_IR  = 4'hB,
        TAP_RTI      = 4'hC, TAP_UPD_IR   = 4'hD, TAP_CAP_IR   = 4'hE, TAP_TLR       = 4'hF
    } tap_state_e;

    // Instruction opcodes
    // Slaves only know IDCODE and BYPASS
    typedef enum logic [`TAP_IR_W-1:0] {
        INSTR_IDCODE = `TAP_OP_IDCODE,
        INSTR_NWSEL  = `TAP_OP_NWSEL,
        INSTR_BYPASS = `TAP_OP_BYPASS
    } tap_instr_e;

endpackage

// File: design/tapnw_pkg.sv
// Network types for the slave enable mask and chain position
`include "tap_consts.svh"

package tapnw_pkg;

    // One enable bit per slave, bit 0 is slave 0
    typedef logic [`TAPNW_NUM_STAPS-1:0] tap_enable_t;

    // Stage that ends the chain and feeds top-level tdo
    typedef enum logic [1:0] {
        POS_MTAP  = 2'd0,
        POS_STAP0 = 2'd1,
        POS_STAP1 = 2'd2
    } tap_pos_e;

endpackage

// File: jtag_top.f
+incdir+design
design/tap_pkg.sv
design/tapnw_pkg.sv
design/tap_if.sv
design/tap_fsm.sv
design/slave_tap.sv
design/master_tap.sv
design/tap_network.sv
design/jtag_top.sv
tests/tb_clock.sv
tests/jtag_top_tb.sv

// File: tests/jtag_top_tb.sv
// Testbench for the TAP network
// Random IR and DR scans checked against a chain model
`timescale 1ns/1ps
`include "tap_consts.svh"

module jtag_top_tb;

    localparam int NUM_ROUNDS     = 24;
    // About 400 cycles per round covers the longest IDCODE chain
    localparam int TIMEOUT_CYCLES = (NUM_ROUNDS + 2) * 400;

    logic                   tck, arst_n, rst_req;
    logic                   tms, tdi, tdo, tdo_en;
    tapnw_pkg::tap_enable_t tap_enable;
    // Chain model, index 0 is the master
    tapnw_pkg::tap_enable_t mdl_enable;
    tap_pkg::tap_instr_e    mdl_ir [3];
    logic [31:0]            lcg_state = 32'h0c673b30;
    logic [31:0]            rnd;
    logic [127:0]           din, dout;
    int                     cycles = 0;

    tb_clock clk_i (.rst_req(rst_req), .tck(tck), .arst_n(arst_n));

    jtag_top dut_i (.tck(tck), .arst_n(arst_n), .tms(tms), .tdi(tdi), .tdo(tdo),
        .tdo_en(tdo_en), .tap_enable(tap_enable));

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [`TAP_ID_W-1:0] got,
                              input logic [`TAP_ID_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_enable(input string name, input tapnw_pkg::tap_enable_t got,
                                input tapnw_pkg::tap_enable_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Chain model
    // --------------------------------------------------
    function automatic int dr_len(input int id);
        case (mdl_ir[id])
            tap_pkg::INSTR_IDCODE: return `TAP_ID_W;
            tap_pkg::INSTR_NWSEL:  return (id == 0) ? `TAPNW_NUM_STAPS : 1;
            default:               return 1;
        endcase
    endfunction

    function automatic logic [`TAP_ID_W-1:0] idcode_of(input int id);
        if (id == 0) return `MTAP_IDCODE;
        return (id == 1) ? `STAP0_IDCODE : `STAP1_IDCODE;
    endfunction

    // --------------------------------------------------
    // Pin level sequencing
    // --------------------------------------------------
    // tms and tdi apply to the state seen at the following falling edge
    task automatic step(input logic t, input logic d, input logic en_exp, output logic o);
        @(posedge tck);
        tms <= t;
        tdi <= d;
        @(negedge tck);
        check_bit("tdo_en", tdo_en, en_exp);
        o = tdo;
    endtask

    // tms bits LSB first, no shifting
    task automatic walk(input logic [7:0] seq, input int n);
        logic o;
        for (int i = 0; i < n; i++) begin
            step(seq[i], 1'b0, 1'b0, o);
        end
    endtask

    // From Run-Test/Idle through a full scan and back
    task automatic scan(input logic ir_scan, input int len);
        logic o;
        walk(ir_scan ? 8'h03 : 8'h01, ir_scan ? 4 : 3);
        for (int i = 0; i < len; i++) begin
            step(i == len - 1, din[i], 1'b1, o);
            dout[i] = o;
        end
        walk(8'h01, 2);
    endtask

    // --------------------------------------------------
    // Checked scans
    // --------------------------------------------------
    // Stage nearest tdo takes the first bits shifted in
    task automatic ir_check(input tap_pkg::tap_instr_e m_ir, input tap_pkg::tap_instr_e s0_ir,
                            input tap_pkg::tap_instr_e s1_ir);
        tap_pkg::tap_instr_e want [3];
        logic [3:0]          cap;
        int                  pos;
        want[0] = m_ir;
        want[1] = s0_ir;
        want[2] = s1_ir;
        cap     = `TAP_IR_CAPTURE;
        pos     = 0;
        for (int id = 2; id >= 0; id--) begin
            if (id == 0 || mdl_enable[id-1]) begin
                din[pos +: 4] = want[id];
                mdl_ir[id]    = want[id];
                pos += 4;
            end
        end
        scan(1'b1, pos);
        for (int i = 0; i < pos; i++) begin
            check_bit("tdo ir capture", dout[i], cap[i % 4]);
        end
    endtask

    // Captures come out tdo side first, then tdi data delayed by the chain
    task automatic dr_check(input int extra, input tapnw_pkg::tap_enable_t load);
        logic [`TAP_ID_W-1:0] word;
        int                   len;
        int                   pos;
        len = 0;
        for (int id = 0; id < 3; id++) begin
            if (id == 0 || mdl_enable[id-1]) len += dr_len(id);
        end
        for (int i = 0; i < 128; i += 32) din[i +: 32] = lcg_next();
        // Master select stage keeps the last bits shifted in
        if (mdl_ir[0] == tap_pkg::INSTR_NWSEL) din[len + extra - 2 +: 2] = load;
        scan(1'b0, len + extra);
        pos = 0;
        for (int id = 2; id >= 0; id--) begin
            if (id == 0 || mdl_enable[id-1]) begin
                word = '0;
                for (int b = 0; b < dr_len(id); b++) word[b] = dout[pos + b];
                case (mdl_ir[id])
                    tap_pkg::INSTR_IDCODE: check_word("tdo idcode", word, idcode_of(id));
                    tap_pkg::INSTR_NWSEL:  check_enable("tdo nwsel", word[1:0], mdl_enable);
                    default:               check_bit("tdo bypass", word[0], 1'b0);
                endcase
                pos += dr_len(id);
            end
        end
        for (int j = 0; j < extra; j++) check_bit("tdo delayed tdi", dout[len + j], din[j]);
        if (mdl_ir[0] == tap_pkg::INSTR_NWSEL) begin
            mdl_enable = load;
            // Disabled slaves settle in Test-Logic-Reset on IDCODE
            walk(8'h00, 6);
            for (int id = 1; id < 3; id++) begin
                if (!mdl_enable[id-1]) mdl_ir[id] = tap_pkg::INSTR_IDCODE;
            end
            check_enable("tap_enable", tap_enable, mdl_enable);
        end
    endtask

    // Into Run-Test/Idle from any state, then the reset checks
    task automatic reset_check();
        mdl_enable = '0;
        for (int id = 0; id < 3; id++) mdl_ir[id] = tap_pkg::INSTR_IDCODE;
        walk(8'h1F, 6);
        walk(8'h00, 2);
        check_enable("tap_enable", tap_enable, mdl_enable);
        dr_check(8, '0);
    endtask

    // arst_n pulse part way through a DR shift
    task automatic reset_mid_scan(input int bits);
        logic o;
        walk(8'h01, 3);
        for (int i = 0; i < bits; i++) step(1'b0, 1'b1, 1'b1, o);
        @(posedge tck);
        tms     <= 1'b1;
        rst_req <= 1'b1;
        repeat (3) @(posedge tck);
        rst_req <= 1'b0;
        reset_check();
    endtask

    // --------------------------------------------------
    // Run limit and test sequence
    // --------------------------------------------------
    always @(posedge tck) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: no result after %0d tck cycles", cycles));
        end
    end

    initial begin
        tms        = 1'b1;
        tdi        = 1'b0;
        rst_req    = 1'b0;
        mdl_enable = '0;
        @(posedge arst_n);
        reset_check();
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            rnd = lcg_next();
            // New mask, then a second NWSEL scan reads it back
            ir_check(tap_pkg::INSTR_NWSEL, tap_pkg::INSTR_BYPASS, tap_pkg::INSTR_BYPASS);
            dr_check(int'(rnd[3:0]), rnd[17:16]);
            dr_check(int'(rnd[7:4]), rnd[19:18]);
            ir_check(tap_pkg::INSTR_IDCODE, tap_pkg::INSTR_IDCODE, tap_pkg::INSTR_IDCODE);
            dr_check(int'(rnd[11:8]), '0);
            ir_check(tap_pkg::INSTR_BYPASS, tap_pkg::INSTR_BYPASS, tap_pkg::INSTR_BYPASS);
            dr_check(4 + int'(rnd[15:12]), '0);
            if (r % 8 == 7) reset_mid_scan(1 + int'(rnd[24:20]));
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
// Clock and power-on reset for the testbench
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_NS      = 2,
    parameter int RESET_CYCLES = 16
) (
    input  logic rst_req,
    output logic tck,
    output logic arst_n
);

    logic por_n;

    // 4 ns period
    initial begin
        tck = 1'b0;
        forever #(HALF_NS) tck = ~tck;
    end

    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge tck);
        por_n <= 1'b1;
    end

    // Extra reset pulses on request from the test
    assign arst_n = por_n & ~rst_req;

endmodule
